//--- verilog/sram_test_pkg.sv
`default_nettype none

package sram_test_pkg;

  localparam int CMD_WIDTH  = 112;
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;
  localparam int MASK_WIDTH = 4;                        // Byte write enables, active high
  localparam int BYTE_WIDTH = DATA_WIDTH / MASK_WIDTH;
  localparam int SEL_WIDTH  = 4;

  // Request bundle of one port as routed by macro_select
  localparam int REQ_WIDTH = 1 + MASK_WIDTH + ADDR_WIDTH + DATA_WIDTH;
  localparam int NUM_MACRO_PORTS = 7;

  // Command field low bits, widths are the ones above
  localparam int SEL_LSB    = 108;
  localparam int ADDR0_LSB  = 92;
  localparam int DIN0_LSB   = 60;
  localparam int CSB0_BIT   = 59;
  localparam int WEB0_BIT   = 58;
  localparam int WMASK0_LSB = 54;
  localparam int ADDR1_LSB  = 38;
  localparam int DIN1_LSB   = 6;
  localparam int CSB1_BIT   = 5;
  localparam int WEB1_BIT   = 4;
  localparam int WMASK1_LSB = 0;

  localparam logic [CMD_WIDTH-1:0] RESET_CMD = CMD_WIDTH'(1);

  // Macro depths in words
  localparam int DEPTH_DP    = 256;
  localparam int DEPTH_SP1K  = 1024;
  localparam int DEPTH_SP256 = 256;
  localparam int DEPTH_SP512 = 512;

  typedef enum logic [SEL_WIDTH-1:0] {
    SEL_DP0   = 4'd0,  // 32x256 dual port
    SEL_DP1   = 4'd1,  // 32x256 dual port
    SEL_SP1K  = 4'd2,  // 32x1024 single port
    SEL_SP256 = 4'd3,  // 32x256 single port
    SEL_SP512 = 4'd4   // 32x512 single port
  } macro_sel_e;

endpackage

`default_nettype wire

//--- verilog/sram_port_if.sv
`default_nettype none

interface sram_port_if
  import sram_test_pkg::*;
();

  logic                  csb;    // Low enables the port
  logic                  web;    // Low writes, high reads
  logic [MASK_WIDTH-1:0] wmask;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] din;
  logic [DATA_WIDTH-1:0] dout;

  // Requester side
  modport host (
    output csb, web, wmask, addr, din,
    input  dout
  );

  // Memory side
  modport target (
    input  csb, web, wmask, addr, din,
    output dout
  );

endinterface

`default_nettype wire

//--- verilog/command_register.sv
`default_nettype none

module command_register
  import sram_test_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 scan_en,
  input  wire logic                 scan_in,
  input  wire logic                 load,
  input  wire logic [CMD_WIDTH-1:0] load_bits,
  input  wire logic                 sram_load,
  sram_port_if.host                 cmd0,
  sram_port_if.host                 cmd1,
  output macro_sel_e                sel,
  output logic [DATA_WIDTH-1:0]     la_data0,
  output logic [DATA_WIDTH-1:0]     la_data1,
  output logic                      scan_data0,
  output logic                      scan_data1
);

  logic [CMD_WIDTH-1:0] cmd_q;
  logic [CMD_WIDTH-1:0] merged;
  logic                 sel_valid;
  logic                 sel_dual;

  assign sel = macro_sel_e'(cmd_q[SEL_LSB +: SEL_WIDTH]);

  assign sel_valid = sel inside {SEL_DP0, SEL_DP1, SEL_SP1K, SEL_SP256, SEL_SP512};
  assign sel_dual  = sel inside {SEL_DP0, SEL_DP1};

  // Read data write-back into the din fields
  always_comb begin
    merged = cmd_q;
    if (!sel_valid) begin
      merged[DIN0_LSB +: DATA_WIDTH] = '0;  // No macro behind it
      merged[DIN1_LSB +: DATA_WIDTH] = '0;
    end else begin
      if (cmd_q[WEB0_BIT])
        merged[DIN0_LSB +: DATA_WIDTH] = cmd0.dout;
      // Single-port macros have no second port to read from
      if (cmd_q[WEB1_BIT] && sel_dual)
        merged[DIN1_LSB +: DATA_WIDTH] = cmd1.dout;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= RESET_CMD;
    end else if (scan_en) begin
      cmd_q <= {cmd_q[CMD_WIDTH-2:0], scan_in};  // Shift in at bit 0
    end else if (load) begin
      cmd_q <= load_bits;
    end else if (sram_load) begin
      cmd_q <= merged;
    end
  end

  // Port 0 fields
  assign cmd0.addr  = cmd_q[ADDR0_LSB +: ADDR_WIDTH];
  assign cmd0.din   = cmd_q[DIN0_LSB +: DATA_WIDTH];
  assign cmd0.csb   = cmd_q[CSB0_BIT];
  assign cmd0.web   = cmd_q[WEB0_BIT];
  assign cmd0.wmask = cmd_q[WMASK0_LSB +: MASK_WIDTH];

  // Port 1 fields
  assign cmd1.addr  = cmd_q[ADDR1_LSB +: ADDR_WIDTH];
  assign cmd1.din   = cmd_q[DIN1_LSB +: DATA_WIDTH];
  assign cmd1.csb   = cmd_q[CSB1_BIT];
  assign cmd1.web   = cmd_q[WEB1_BIT];
  assign cmd1.wmask = cmd_q[WMASK1_LSB +: MASK_WIDTH];

  assign la_data0 = cmd_q[DIN0_LSB +: DATA_WIDTH];
  assign la_data1 = cmd_q[DIN1_LSB +: DATA_WIDTH];

  // MSB of each din field leaves first while shifting
  assign scan_data0 = cmd_q[DIN0_LSB + DATA_WIDTH - 1];
  assign scan_data1 = cmd_q[DIN1_LSB + DATA_WIDTH - 1];

endmodule

`default_nettype wire

//--- verilog/macro_select.sv
`default_nettype none

module macro_select
  import sram_test_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        issue,
  input  wire logic        scan_en,
  input  wire logic        load,
  input  wire macro_sel_e  sel,
  sram_port_if.target      cmd0,
  sram_port_if.target      cmd1,
  sram_port_if.host        dp0_p0,
  sram_port_if.host        dp0_p1,
  sram_port_if.host        dp1_p0,
  sram_port_if.host        dp1_p1,
  sram_port_if.host        sp1k_p0,
  sram_port_if.host        sp256_p0,
  sram_port_if.host        sp512_p0
);

  logic                       fire;
  logic                       go0;
  logic                       go1;
  logic                       hit_dp0, hit_dp1, hit_sp1k, hit_sp256, hit_sp512;
  logic [REQ_WIDTH-1:0]       req0;
  logic [REQ_WIDTH-1:0]       req1;
  logic [NUM_MACRO_PORTS-1:0] port_en;
  logic [NUM_MACRO_PORTS-1:0] en_q;
  logic [DATA_WIDTH-1:0]      port_dout [NUM_MACRO_PORTS];
  logic [DATA_WIDTH-1:0]      cap_q [NUM_MACRO_PORTS];

  // Issue does not count while the command is changing
  assign fire = issue && !scan_en && !load;
  assign go0  = fire && !cmd0.csb;
  assign go1  = fire && !cmd1.csb;

  assign hit_dp0   = (sel == SEL_DP0);
  assign hit_dp1   = (sel == SEL_DP1);
  assign hit_sp1k  = (sel == SEL_SP1K);
  assign hit_sp256 = (sel == SEL_SP256);
  assign hit_sp512 = (sel == SEL_SP512);

  assign req0 = {cmd0.web, cmd0.wmask, cmd0.addr, cmd0.din};
  assign req1 = {cmd1.web, cmd1.wmask, cmd1.addr, cmd1.din};

  // Deselected macros idle at all ones
  assign dp0_p0.csb   = !(hit_dp0 && go0);
  assign dp0_p1.csb   = !(hit_dp0 && go1);
  assign dp1_p0.csb   = !(hit_dp1 && go0);
  assign dp1_p1.csb   = !(hit_dp1 && go1);
  assign sp1k_p0.csb  = !(hit_sp1k && go0);
  assign sp256_p0.csb = !(hit_sp256 && go0);
  assign sp512_p0.csb = !(hit_sp512 && go0);

  assign {dp0_p0.web, dp0_p0.wmask, dp0_p0.addr, dp0_p0.din} = hit_dp0 ? req0 : '1;
  assign {dp0_p1.web, dp0_p1.wmask, dp0_p1.addr, dp0_p1.din} = hit_dp0 ? req1 : '1;
  assign {dp1_p0.web, dp1_p0.wmask, dp1_p0.addr, dp1_p0.din} = hit_dp1 ? req0 : '1;
  assign {dp1_p1.web, dp1_p1.wmask, dp1_p1.addr, dp1_p1.din} = hit_dp1 ? req1 : '1;
  assign {sp1k_p0.web, sp1k_p0.wmask, sp1k_p0.addr, sp1k_p0.din} = hit_sp1k ? req0 : '1;
  assign {sp256_p0.web, sp256_p0.wmask, sp256_p0.addr, sp256_p0.din} =
    hit_sp256 ? req0 : '1;
  assign {sp512_p0.web, sp512_p0.wmask, sp512_p0.addr, sp512_p0.din} =
    hit_sp512 ? req0 : '1;

  assign port_en = ~{sp512_p0.csb, sp256_p0.csb, sp1k_p0.csb,
                     dp1_p1.csb, dp1_p0.csb, dp0_p1.csb, dp0_p0.csb};

  assign port_dout[0] = dp0_p0.dout;
  assign port_dout[1] = dp0_p1.dout;
  assign port_dout[2] = dp1_p0.dout;
  assign port_dout[3] = dp1_p1.dout;
  assign port_dout[4] = sp1k_p0.dout;
  assign port_dout[5] = sp256_p0.dout;
  assign port_dout[6] = sp512_p0.dout;

  // Macro dout settles one edge after the access, take it on the next
  always_ff @(posedge clk) begin
    if (reset) begin
      en_q <= '0;
      for (int i = 0; i < NUM_MACRO_PORTS; i++)
        cap_q[i] <= '0;
    end else begin
      en_q <= port_en;
      for (int i = 0; i < NUM_MACRO_PORTS; i++) begin
        if (en_q[i])
          cap_q[i] <= port_dout[i];
      end
    end
  end

  always_comb begin
    cmd0.dout = '0;
    cmd1.dout = '0;  // Single-port macros return nothing on port 1
    case (sel)
      SEL_DP0: begin
        cmd0.dout = cap_q[0];
        cmd1.dout = cap_q[1];
      end
      SEL_DP1: begin
        cmd0.dout = cap_q[2];
        cmd1.dout = cap_q[3];
      end
      SEL_SP1K:  cmd0.dout = cap_q[4];
      SEL_SP256: cmd0.dout = cap_q[5];
      SEL_SP512: cmd0.dout = cap_q[6];
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/sram_dual_port.sv
`default_nettype none

module sram_dual_port
  import sram_test_pkg::*;
#(
  parameter int DEPTH = DEPTH_DP
) (
  input  wire logic   clk,
  sram_port_if.target p0,  // Read-write
  sram_port_if.target p1   // Read-only
);

  localparam int AW = $clog2(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]         addr0;
  logic [AW-1:0]         addr1;

  // Upper address bits are ignored so accesses wrap
  assign addr0 = p0.addr[AW-1:0];
  assign addr1 = p1.addr[AW-1:0];

  always_ff @(posedge clk) begin
    if (!p0.csb) begin
      if (!p0.web) begin
        for (int b = 0; b < MASK_WIDTH; b++) begin
          if (p0.wmask[b])
            mem[addr0][b*BYTE_WIDTH +: BYTE_WIDTH] <= p0.din[b*BYTE_WIDTH +: BYTE_WIDTH];
        end
      end else begin
        p0.dout <= mem[addr0];
      end
    end
  end

  // Same-address read during a port 0 write returns the old word
  always_ff @(posedge clk) begin
    if (!p1.csb)
      p1.dout <= mem[addr1];
  end

endmodule

`default_nettype wire

//--- verilog/sram_single_port.sv
`default_nettype none

module sram_single_port
  import sram_test_pkg::*;
#(
  parameter int DEPTH = DEPTH_SP256
) (
  input  wire logic   clk,
  sram_port_if.target p0
);

  localparam int AW = $clog2(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]         addr;

  assign addr = p0.addr[AW-1:0];  // Wraps past the depth

  always_ff @(posedge clk) begin
    if (!p0.csb) begin
      if (!p0.web) begin
        // Byte lanes under wmask
        for (int b = 0; b < MASK_WIDTH; b++) begin
          if (p0.wmask[b])
            mem[addr][b*BYTE_WIDTH +: BYTE_WIDTH] <= p0.din[b*BYTE_WIDTH +: BYTE_WIDTH];
        end
      end else begin
        p0.dout <= mem[addr];  // Holds until the next read
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/sram_test_top.sv
`default_nettype none

module sram_test_top
  import sram_test_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  scan_en,
  input  wire logic                  scan_in,
  input  wire logic                  load,
  input  wire logic [CMD_WIDTH-1:0]  load_bits,
  input  wire logic                  issue,
  input  wire logic                  sram_load,
  output logic      [DATA_WIDTH-1:0] la_data0,
  output logic      [DATA_WIDTH-1:0] la_data1,
  output logic                       scan_data0,
  output logic                       scan_data1
);

  macro_sel_e sel;

  // Command side ports
  sram_port_if cmd0 ();
  sram_port_if cmd1 ();

  // Macro side ports
  sram_port_if dp0_p0 ();
  sram_port_if dp0_p1 ();
  sram_port_if dp1_p0 ();
  sram_port_if dp1_p1 ();
  sram_port_if sp1k_p0 ();
  sram_port_if sp256_p0 ();
  sram_port_if sp512_p0 ();

  command_register u_command_register (
    .clk        (clk),
    .reset      (reset),
    .scan_en    (scan_en),
    .scan_in    (scan_in),
    .load       (load),
    .load_bits  (load_bits),
    .sram_load  (sram_load),
    .cmd0       (cmd0.host),
    .cmd1       (cmd1.host),
    .sel        (sel),
    .la_data0   (la_data0),
    .la_data1   (la_data1),
    .scan_data0 (scan_data0),
    .scan_data1 (scan_data1)
  );

  macro_select u_macro_select (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .scan_en  (scan_en),
    .load     (load),
    .sel      (sel),
    .cmd0     (cmd0.target),
    .cmd1     (cmd1.target),
    .dp0_p0   (dp0_p0.host),
    .dp0_p1   (dp0_p1.host),
    .dp1_p0   (dp1_p0.host),
    .dp1_p1   (dp1_p1.host),
    .sp1k_p0  (sp1k_p0.host),
    .sp256_p0 (sp256_p0.host),
    .sp512_p0 (sp512_p0.host)
  );

  // Macros 0 and 1, 32x256 dual port
  sram_dual_port #(.DEPTH(DEPTH_DP)) u_sram_dp0 (
    .clk (clk),
    .p0  (dp0_p0.target),
    .p1  (dp0_p1.target)
  );

  sram_dual_port #(.DEPTH(DEPTH_DP)) u_sram_dp1 (
    .clk (clk),
    .p0  (dp1_p0.target),
    .p1  (dp1_p1.target)
  );

  // Macros 2 to 4, single port
  sram_single_port #(.DEPTH(DEPTH_SP1K)) u_sram_sp1k (
    .clk (clk),
    .p0  (sp1k_p0.target)
  );

  sram_single_port #(.DEPTH(DEPTH_SP256)) u_sram_sp256 (
    .clk (clk),
    .p0  (sp256_p0.target)
  );

  sram_single_port #(.DEPTH(DEPTH_SP512)) u_sram_sp512 (
    .clk (clk),
    .p0  (sp512_p0.target)
  );

endmodule

`default_nettype wire

//--- tb/tb_sram_test_top.sv
`default_nettype none

module tb_sram_test_top
  import sram_test_pkg::*;
();

  logic                  clk;
  logic                  reset;
  logic                  scan_en;
  logic                  scan_in;
  logic                  load;
  logic [CMD_WIDTH-1:0]  load_bits;
  logic                  issue;
  logic                  sram_load;
  logic [DATA_WIDTH-1:0] la_data0;
  logic [DATA_WIDTH-1:0] la_data1;
  logic                  scan_data0;
  logic                  scan_data1;

  integer seed;
  int     errors;
  int     tests;

  // Reference contents of the five macros, indexed by macro select
  logic [DATA_WIDTH-1:0] ref_mem [5][DEPTH_SP1K];

  sram_test_top u_sram_test_top (
    .clk        (clk),
    .reset      (reset),
    .scan_en    (scan_en),
    .scan_in    (scan_in),
    .load       (load),
    .load_bits  (load_bits),
    .issue      (issue),
    .sram_load  (sram_load),
    .la_data0   (la_data0),
    .la_data1   (la_data1),
    .scan_data0 (scan_data0),
    .scan_data1 (scan_data1)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int depth_of(input int sel);
    case (sel)
      SEL_DP0, SEL_DP1: return DEPTH_DP;
      SEL_SP1K:         return DEPTH_SP1K;
      SEL_SP256:        return DEPTH_SP256;
      default:          return DEPTH_SP512;
    endcase
  endfunction

  // Packs the command fields at their bit positions
  function automatic logic [CMD_WIDTH-1:0] make_cmd(
    input logic [SEL_WIDTH-1:0]  sel,
    input logic [ADDR_WIDTH-1:0] addr0,
    input logic [DATA_WIDTH-1:0] din0,
    input logic                  csb0,
    input logic                  web0,
    input logic [MASK_WIDTH-1:0] wmask0,
    input logic [ADDR_WIDTH-1:0] addr1,
    input logic [DATA_WIDTH-1:0] din1,
    input logic                  csb1,
    input logic                  web1,
    input logic [MASK_WIDTH-1:0] wmask1
  );
    logic [CMD_WIDTH-1:0] cmd;
    cmd = '0;
    cmd[SEL_LSB +: SEL_WIDTH]     = sel;
    cmd[ADDR0_LSB +: ADDR_WIDTH]  = addr0;
    cmd[DIN0_LSB +: DATA_WIDTH]   = din0;
    cmd[CSB0_BIT]                 = csb0;
    cmd[WEB0_BIT]                 = web0;
    cmd[WMASK0_LSB +: MASK_WIDTH] = wmask0;
    cmd[ADDR1_LSB +: ADDR_WIDTH]  = addr1;
    cmd[DIN1_LSB +: DATA_WIDTH]   = din1;
    cmd[CSB1_BIT]                 = csb1;
    cmd[WEB1_BIT]                 = web1;
    cmd[WMASK1_LSB +: MASK_WIDTH] = wmask1;
    return cmd;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_WIDTH-1:0] expected,
                                 input logic [DATA_WIDTH-1:0] actual);
    errors++;
    $display("Mismatch in test %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - start);
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(posedge clk);
  endtask

  // Issue, wait two cycles for the capture, then write the read data back
  task automatic fetch_result();
    @(posedge clk);
    issue <= 1'b1;
    @(posedge clk);      // Access edge
    issue <= 1'b0;
    wait_cycles(1);      // Capture edge
    sram_load <= 1'b1;
    @(posedge clk);
    sram_load <= 1'b0;
    @(negedge clk);      // Sample away from the rising edge
  endtask

  task automatic run_command(input logic [CMD_WIDTH-1:0] cmd);
    @(posedge clk);
    load      <= 1'b1;
    load_bits <= cmd;
    @(posedge clk);
    load <= 1'b0;
    fetch_result();
  endtask

  // First bit sent ends up in bit 111
  task automatic shift_command(input logic [CMD_WIDTH-1:0] cmd);
    for (int i = CMD_WIDTH - 1; i >= 0; i--) begin
      @(posedge clk);
      scan_en <= 1'b1;
      scan_in <= cmd[i];
    end
    @(posedge clk);
    scan_en <= 1'b0;
    scan_in <= 1'b0;
  endtask

  task automatic write_word(input int sel, input int addr, input logic [DATA_WIDTH-1:0] data,
                            input logic [MASK_WIDTH-1:0] mask);
    int a;
    a = addr % depth_of(sel);
    run_command(make_cmd(SEL_WIDTH'(sel), ADDR_WIDTH'(addr), data, 1'b0, 1'b0, mask,
                         '0, '0, 1'b1, 1'b0, '0));
    for (int b = 0; b < MASK_WIDTH; b++) begin
      if (mask[b])
        ref_mem[sel][a][b*BYTE_WIDTH +: BYTE_WIDTH] = data[b*BYTE_WIDTH +: BYTE_WIDTH];
    end
  endtask

  task automatic read_check(input int sel, input int addr, input string name);
    logic [DATA_WIDTH-1:0] expected;
    expected = ref_mem[sel][addr % depth_of(sel)];
    run_command(make_cmd(SEL_WIDTH'(sel), ADDR_WIDTH'(addr), '0, 1'b0, 1'b1, '0,
                         '0, '0, 1'b1, 1'b0, '0));
    if (la_data0 !== expected)
      report_mismatch(name, expected, la_data0);
  endtask

  task automatic reset_state();
    int start;
    start = errors;
    @(negedge clk);
    if (la_data0 !== '0)
      report_mismatch("reset", '0, la_data0);
    if (la_data1 !== '0)
      report_mismatch("reset", '0, la_data1);
    if ({scan_data1, scan_data0} !== 2'b00)
      report_mismatch("reset", '0, DATA_WIDTH'({scan_data1, scan_data0}));
    // Reset command has both web bits low and no byte enabled on port 0
    fetch_result();
    if (la_data0 !== '0)
      report_mismatch("reset_issue", '0, la_data0);
    if (la_data1 !== '0)
      report_mismatch("reset_issue", '0, la_data1);
    finish_test("reset", start);
  endtask

  task automatic single_port_access();
    int                    start;
    int                    addrs [4];
    logic [DATA_WIDTH-1:0] data;
    start = errors;
    for (int s = SEL_SP1K; s <= SEL_SP512; s++) begin
      for (int i = 0; i < 4; i++) begin
        addrs[i] = $unsigned($random(seed)) % depth_of(s);
        data = $random(seed);
        write_word(s, addrs[i], data, 4'hf);
      end
      for (int i = 0; i < 4; i++)
        read_check(s, addrs[i], "single_port");
      // One and two depths up land on the same words
      data = $random(seed);
      write_word(s, addrs[0] + depth_of(s), data, 4'hf);
      read_check(s, addrs[0], "single_port_wrap");
      read_check(s, addrs[1] + 2 * depth_of(s), "single_port_wrap");
    end
    finish_test("single_port", start);
  endtask

  task automatic byte_mask_write();
    int start;
    start = errors;
    for (int s = SEL_DP1; s <= SEL_SP256; s += 2) begin
      write_word(s, 17, $random(seed), 4'hf);
      write_word(s, 17, $random(seed), 4'b0101);
      read_check(s, 17, "byte_mask");
      write_word(s, 17, $random(seed), 4'b1000);
      read_check(s, 17, "byte_mask");
      write_word(s, 17, $random(seed), 4'b0000);  // No lane enabled
      read_check(s, 17, "byte_mask");
    end
    finish_test("byte_mask", start);
  endtask

  task automatic dual_port_access();
    int                    start;
    int                    a;
    int                    b;
    logic [DATA_WIDTH-1:0] marker;
    start = errors;
    a = $unsigned($random(seed)) % DEPTH_DP;
    b = (a + 37) % DEPTH_DP;
    write_word(SEL_DP1, a, $random(seed), 4'hf);
    write_word(SEL_DP0, a, $random(seed), 4'hf);
    write_word(SEL_DP0, b, $random(seed), 4'hf);
    run_command(make_cmd(SEL_DP0, ADDR_WIDTH'(a), '0, 1'b0, 1'b1, '0,
                         ADDR_WIDTH'(b), '0, 1'b0, 1'b1, '0));
    if (la_data0 !== ref_mem[SEL_DP0][a])
      report_mismatch("dual_port", ref_mem[SEL_DP0][a], la_data0);
    if (la_data1 !== ref_mem[SEL_DP0][b])
      report_mismatch("dual_port", ref_mem[SEL_DP0][b], la_data1);
    // Macro 1 keeps its own word at the address written in macro 0
    run_command(make_cmd(SEL_DP1, ADDR_WIDTH'(a), '0, 1'b0, 1'b1, '0,
                         ADDR_WIDTH'(a), '0, 1'b0, 1'b1, '0));
    if (la_data0 !== ref_mem[SEL_DP1][a])
      report_mismatch("dual_port_isolation", ref_mem[SEL_DP1][a], la_data0);
    if (la_data1 !== ref_mem[SEL_DP1][a])
      report_mismatch("dual_port_isolation", ref_mem[SEL_DP1][a], la_data1);
    marker = $random(seed);
    run_command(make_cmd(SEL_DP0, ADDR_WIDTH'(a), '0, 1'b0, 1'b1, '0,
                         ADDR_WIDTH'(b), marker, 1'b0, 1'b0, '0));
    if (la_data0 !== ref_mem[SEL_DP0][a])
      report_mismatch("dual_port_web1", ref_mem[SEL_DP0][a], la_data0);
    if (la_data1 !== marker)
      report_mismatch("dual_port_web1", marker, la_data1);
    finish_test("dual_port", start);
  endtask

  task automatic serial_path();
    int                    start;
    int                    a;
    int                    b;
    logic [DATA_WIDTH-1:0] din0;
    logic [DATA_WIDTH-1:0] din1;
    logic [DATA_WIDTH-1:0] got0;
    logic [DATA_WIDTH-1:0] got1;
    logic [CMD_WIDTH-1:0]  cmd;
    start = errors;
    a = $unsigned($random(seed)) % DEPTH_DP;
    b = (a + 101) % DEPTH_DP;
    write_word(SEL_DP1, a, $random(seed), 4'hf);
    write_word(SEL_DP1, b, $random(seed), 4'hf);
    din0 = $random(seed);
    din1 = $random(seed);
    cmd = make_cmd(SEL_DP1, ADDR_WIDTH'(a), din0, 1'b0, 1'b1, '0,
                   ADDR_WIDTH'(b), din1, 1'b0, 1'b1, '0);
    shift_command(cmd);
    @(negedge clk);
    if (la_data0 !== din0)
      report_mismatch("serial_in", din0, la_data0);
    if (la_data1 !== din1)
      report_mismatch("serial_in", din1, la_data1);
    fetch_result();
    if (la_data0 !== ref_mem[SEL_DP1][a])
      report_mismatch("serial_read", ref_mem[SEL_DP1][a], la_data0);
    if (la_data1 !== ref_mem[SEL_DP1][b])
      report_mismatch("serial_read", ref_mem[SEL_DP1][b], la_data1);
    // Same command over the parallel load
    run_command(cmd);
    if (la_data0 !== ref_mem[SEL_DP1][a])
      report_mismatch("parallel_read", ref_mem[SEL_DP1][a], la_data0);
    if (la_data1 !== ref_mem[SEL_DP1][b])
      report_mismatch("parallel_read", ref_mem[SEL_DP1][b], la_data1);
    @(posedge clk);
    scan_en <= 1'b1;
    scan_in <= 1'b0;
    for (int k = 0; k < DATA_WIDTH; k++) begin
      @(negedge clk);
      got0 = {got0[DATA_WIDTH-2:0], scan_data0};  // MSB comes out first
      got1 = {got1[DATA_WIDTH-2:0], scan_data1};
      @(posedge clk);
    end
    scan_en <= 1'b0;
    if (got0 !== ref_mem[SEL_DP1][a])
      report_mismatch("serial_out", ref_mem[SEL_DP1][a], got0);
    if (got1 !== ref_mem[SEL_DP1][b])
      report_mismatch("serial_out", ref_mem[SEL_DP1][b], got1);
    finish_test("serial", start);
  endtask

  task automatic unused_select();
    int start;
    int addr;
    start = errors;
    // One address below every depth, so a stray write to any macro hits a checked word
    addr = $unsigned($random(seed)) % DEPTH_DP;
    for (int m = SEL_DP0; m <= SEL_SP512; m++)
      write_word(m, addr, $random(seed), 4'hf);
    for (int s = 5; s < 16; s++) begin
      run_command(make_cmd(SEL_WIDTH'(s), ADDR_WIDTH'(addr), $random(seed),
                           1'b0, 1'b0, 4'hf, ADDR_WIDTH'(addr), $random(seed),
                           1'b0, 1'b0, 4'hf));
      if (la_data0 !== '0)
        report_mismatch("unused_sel", '0, la_data0);
      if (la_data1 !== '0)
        report_mismatch("unused_sel", '0, la_data1);
    end
    for (int m = SEL_DP0; m <= SEL_SP512; m++)
      read_check(m, addr, "unused_sel_contents");
    finish_test("unused_sel", start);
  endtask

  initial begin
    reset     = 1'b1;
    scan_en   = 1'b0;
    scan_in   = 1'b0;
    load      = 1'b0;
    load_bits = '0;
    issue     = 1'b0;
    sram_load = 1'b0;
    seed      = 19725;
    errors    = 0;
    tests     = 0;
    wait_cycles(10);
    reset <= 1'b0;

    reset_state();
    single_port_access();
    byte_mask_write();
    dual_port_access();
    serial_path();
    unused_select();

    wait_cycles(2);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/sram_test_pkg.sv
verilog/sram_port_if.sv
verilog/command_register.sv
verilog/macro_select.sv
verilog/sram_dual_port.sv
verilog/sram_single_port.sv
verilog/sram_test_top.sv
tb/tb_sram_test_top.sv

//--- Makefile
# Verilator lint and simulation of the SRAM test chip core

VERILATOR  ?= verilator
FILELIST   ?= src.f
RTL_TOP    ?= sram_test_top
TB_TOP     ?= tb_sram_test_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
PASS_MSG   ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) \
	  --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
